// File: rtl/MilSpiPkg.sv
package MilSpiPkg;

  // word and buffer sizing
  localparam int WORD_W     = 16;
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;   // pointer width, log2 of depth
  localparam int CNT_W      = 5;   // one more bit so a full FIFO reads 16

  // address this block answers to
  localparam logic [7:0] BLOCK_ADDR = 8'hAB;

  // minimum spacing of MIL transmit strobes, in clk cycles
  localparam int MIL_WORD_GAP = 20;

  // command codes carried in the low byte of the SPI header
  typedef enum logic [7:0] {
    CMD_UNKNOWN      = 8'h00,
    CMD_RESET        = 8'h01,
    CMD_SEND_DATA    = 8'h02,  // host -> MIL
    CMD_RECEIVE_STS  = 8'h03,  // FIFO fill levels -> host
    CMD_RECEIVE_DATA = 8'h04   // MIL -> host
  } TCommandCode;

  // first word of every SPI frame
  typedef struct packed {
    logic [7:0]  addr;
    TCommandCode cmd;
  } TSpiHeader;

  // one strobed word on the MIL side, both directions
  typedef struct packed {
    logic              strobe;
    logic [WORD_W-1:0] data;
  } TMilWord;

endpackage

// File: rtl/SpiLink.sv
module SpiLink import MilSpiPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              sclk,
  input  logic              csN,
  input  logic              mosi,
  output logic              miso,
  output logic              hdrStrobe,
  output TSpiHeader         hdr,
  output logic              rxStrobe,
  output logic [WORD_W-1:0] rxData,
  output logic              txPop,
  input  logic [WORD_W-1:0] txData,
  output logic              frameEnd
);

  typedef enum logic [1:0] {IDLE, HEADER, DATA} TLinkState;

  logic [2:0] sclkSync;
  logic [2:0] csSync;
  logic [1:0] mosiSync;
  logic sclkRise;
  logic sclkFall;
  logic csRise;
  logic csActive;
  logic mosiBit;
  TLinkState state;
  logic [$clog2(WORD_W)-1:0] bitCnt;
  logic [WORD_W-1:0] shiftIn;
  logic [WORD_W-1:0] shiftOut;
  logic [WORD_W-1:0] wordIn;

  // two-flop synchronizers, third stage for edge detect
  always_ff @(posedge clk) begin
    if (rst) begin
      sclkSync <= '0;
      csSync   <= '1;  // csN idles high
      mosiSync <= '0;
    end else begin
      sclkSync <= {sclkSync[1:0], sclk};
      csSync   <= {csSync[1:0], csN};
      mosiSync <= {mosiSync[0], mosi};
    end
  end

  assign sclkRise = sclkSync[1] & ~sclkSync[2];
  assign sclkFall = ~sclkSync[1] & sclkSync[2];
  assign csRise   = csSync[1] & ~csSync[2];
  assign csActive = ~csSync[1];
  assign mosiBit  = mosiSync[1];  // same delay as sclk, so aligned with sclkRise
  assign wordIn   = {shiftIn[WORD_W-2:0], mosiBit};

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      bitCnt    <= '0;
      hdrStrobe <= 1'b0;
      rxStrobe  <= 1'b0;
      txPop     <= 1'b0;
      frameEnd  <= 1'b0;
      miso      <= 1'b0;
      shiftOut  <= '0;
    end else begin
      hdrStrobe <= 1'b0;
      rxStrobe  <= 1'b0;
      txPop     <= 1'b0;
      frameEnd  <= csRise;
      case (state)
        IDLE: begin
          if (csActive) begin
            state    <= HEADER;
            bitCnt   <= '0;
            shiftOut <= '0;  // miso stays low through the header
            miso     <= 1'b0;
          end
        end
        default: begin
          if (!csActive) begin
            state <= IDLE;
            miso  <= 1'b0;
          end else begin
            if (sclkRise) begin
              bitCnt <= bitCnt + 1'b1;
              if (bitCnt == '1) begin  // 16th bit of a word
                txPop <= 1'b1;
                if (state == HEADER) begin
                  hdrStrobe <= 1'b1;
                  state     <= DATA;
                end else begin
                  rxStrobe <= 1'b1;
                end
              end
            end
            // mode 0, slave drives the next bit after each falling edge
            if (sclkFall) begin
              miso     <= shiftOut[WORD_W-1];
              shiftOut <= shiftOut << 1;
            end
            if (txPop) shiftOut <= txData;  // next reply word, falls are well clear
          end
        end
      endcase
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (sclkRise) shiftIn <= wordIn;
    if (sclkRise && bitCnt == '1) begin
      if (state == HEADER) hdr <= TSpiHeader'(wordIn);
      else rxData <= wordIn;
    end
  end

endmodule

// File: rtl/WordFifo.sv
module WordFifo import MilSpiPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  logic [WORD_W-1:0] writeData,
  input  logic              pop,
  output logic [WORD_W-1:0] readData,
  output logic              empty,
  output logic              full,
  output logic [CNT_W-1:0]  used
);

  logic [WORD_W-1:0] mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wrPtr;
  logic [FIFO_AW-1:0] rdPtr;
  logic doPush;
  logic doPop;

  assign empty = (used == '0);
  assign full  = (used == CNT_W'(FIFO_DEPTH));

  // overflow and underflow are silently dropped
  assign doPush = push & ~full;
  assign doPop  = pop & ~empty;

  assign readData = mem[rdPtr];  // fall-through, oldest word always visible

  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= writeData;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      used  <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;  // wraps at depth
      if (doPop) rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

endmodule

// File: rtl/MilSpiBlock.sv
module MilSpiBlock import MilSpiPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              hdrStrobe,
  input  TSpiHeader         hdr,
  input  logic              rxStrobe,
  input  logic [WORD_W-1:0] rxData,
  input  logic              txPop,
  input  logic              frameEnd,
  output logic [WORD_W-1:0] txData,
  output logic              toMilPush,
  output logic [WORD_W-1:0] toMilData,
  output logic              fromMilPop,
  input  logic [WORD_W-1:0] fromMilData,
  input  logic [CNT_W-1:0]  toMilUsed,
  input  logic [CNT_W-1:0]  fromMilUsed,
  output logic              resetRequest
);

  TCommandCode cmd;
  TCommandCode hdrCmd;
  TCommandCode activeCmd;
  logic [1:0] wordIdx;    // saturates at 2, later status words are zero
  logic [1:0] activeIdx;
  logic fromMilEmpty;

  // address filter
  assign hdrCmd = (hdr.addr == BLOCK_ADDR) ? hdr.cmd : CMD_UNKNOWN;

  // first txPop shares its cycle with hdrStrobe, before cmd is latched
  assign activeCmd = hdrStrobe ? hdrCmd : cmd;
  assign activeIdx = hdrStrobe ? 2'd0 : wordIdx;

  assign fromMilEmpty = (fromMilUsed == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd          <= CMD_UNKNOWN;
      wordIdx      <= '0;
      resetRequest <= 1'b0;
    end else begin
      if (hdrStrobe) cmd <= hdrCmd;
      else if (frameEnd) cmd <= CMD_UNKNOWN;  // command lives for one frame

      if (txPop) wordIdx <= (activeIdx == 2'd2) ? activeIdx : activeIdx + 2'd1;

      // sticky until rst
      if (hdrStrobe && hdrCmd == CMD_RESET) resetRequest <= 1'b1;
    end
  end

  // reply word presented on txPop
  always_comb begin
    txData = '0;
    case (activeCmd)
      CMD_RECEIVE_STS: begin
        case (activeIdx)
          2'd0:    txData = WORD_W'(fromMilUsed);
          2'd1:    txData = WORD_W'(toMilUsed);
          default: txData = '0;
        endcase
      end
      CMD_RECEIVE_DATA: begin
        if (!fromMilEmpty) txData = fromMilData;  // zero once drained
      end
      default: txData = '0;
    endcase
  end

  // routing
  assign toMilPush  = rxStrobe && (cmd == CMD_SEND_DATA);
  assign toMilData  = rxData;
  assign fromMilPop = txPop && (activeCmd == CMD_RECEIVE_DATA) && !fromMilEmpty;

endmodule

// File: rtl/MilTxPacer.sv
module MilTxPacer import MilSpiPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              empty,
  input  logic [WORD_W-1:0] readData,
  output logic              pop,
  output TMilWord           milTx
);

  logic [$clog2(MIL_WORD_GAP)-1:0] gapCnt;

  // next pop no earlier than MIL_WORD_GAP cycles after the last one
  assign pop = ~empty && (gapCnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      gapCnt <= '0;
      milTx  <= '0;
    end else begin
      milTx.strobe <= pop;  // one cycle after the pop
      if (pop) begin
        milTx.data <= readData;
        gapCnt     <= ($clog2(MIL_WORD_GAP))'(MIL_WORD_GAP - 1);
      end else if (gapCnt != '0) begin
        gapCnt <= gapCnt - 1'b1;
      end
    end
  end

endmodule

// File: rtl/MilSpiBridge.sv
module MilSpiBridge import MilSpiPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    sclk,
  input  logic    csN,
  input  logic    mosi,
  output logic    miso,
  input  TMilWord milRx,
  output TMilWord milTx,
  output logic    resetRequest
);

  TSpiHeader hdr;
  logic hdrStrobe;
  logic rxStrobe;
  logic txPop;
  logic frameEnd;
  logic [WORD_W-1:0] rxData;
  logic [WORD_W-1:0] txData;
  logic toMilPush;
  logic toMilPop;
  logic toMilEmpty;
  logic fromMilPop;
  logic [WORD_W-1:0] toMilData;
  logic [WORD_W-1:0] toMilReadData;
  logic [WORD_W-1:0] fromMilData;
  logic [CNT_W-1:0] toMilUsed;
  logic [CNT_W-1:0] fromMilUsed;

  SpiLink spiLink (
    .clk(clk), .rst(rst),
    .sclk(sclk), .csN(csN), .mosi(mosi), .miso(miso),
    .hdrStrobe(hdrStrobe), .hdr(hdr),
    .rxStrobe(rxStrobe), .rxData(rxData),
    .txPop(txPop), .txData(txData),
    .frameEnd(frameEnd)
  );

  // host -> MIL
  WordFifo fifoToMil (
    .clk(clk), .rst(rst),
    .push(toMilPush), .writeData(toMilData),
    .pop(toMilPop), .readData(toMilReadData),
    .empty(toMilEmpty), .full(), .used(toMilUsed)
  );

  // MIL -> host, words beyond capacity are lost
  WordFifo fifoFromMil (
    .clk(clk), .rst(rst),
    .push(milRx.strobe), .writeData(milRx.data),
    .pop(fromMilPop), .readData(fromMilData),
    .empty(), .full(), .used(fromMilUsed)
  );

  MilSpiBlock milSpiBlock (
    .clk(clk), .rst(rst),
    .hdrStrobe(hdrStrobe), .hdr(hdr),
    .rxStrobe(rxStrobe), .rxData(rxData),
    .txPop(txPop), .frameEnd(frameEnd), .txData(txData),
    .toMilPush(toMilPush), .toMilData(toMilData),
    .fromMilPop(fromMilPop), .fromMilData(fromMilData),
    .toMilUsed(toMilUsed), .fromMilUsed(fromMilUsed),
    .resetRequest(resetRequest)
  );

  MilTxPacer milTxPacer (
    .clk(clk), .rst(rst),
    .empty(toMilEmpty), .readData(toMilReadData),
    .pop(toMilPop), .milTx(milTx)
  );

endmodule

// File: sim/MilSpiBridge_sva.sv
module MilSpiBridgeSva import MilSpiPkg::*; (
  input logic    clk,
  input logic    rst,
  input TMilWord milTx,
  input logic    resetRequest,
  input logic    hdrStrobe,
  input logic    rxStrobe,
  input logic    txPop,
  input logic    frameEnd
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] sinceStrobe;  // cycles since the last milTx strobe, saturating

  always_ff @(posedge clk) begin
    if (rst) sinceStrobe <= 8'(MIL_WORD_GAP);  // first word after reset is free
    else if (milTx.strobe) sinceStrobe <= 8'd1;
    else if (sinceStrobe != '1) sinceStrobe <= sinceStrobe + 8'd1;
  end

  gapKept: assert property (@(posedge clk) disable iff (rst)
    milTx.strobe |-> sinceStrobe >= 8'(MIL_WORD_GAP))
    else $error("milTx strobes closer than %0d cycles", MIL_WORD_GAP);

  // request is sticky
  requestHeld: assert property (@(posedge clk) $fell(resetRequest) |-> $past(rst))
    else $error("resetRequest dropped without rst");

  quietAfterReset: assert property (@(posedge clk)
    rst |=> !(milTx.strobe | hdrStrobe | rxStrobe | txPop | frameEnd | resetRequest))
    else $error("strobe or resetRequest high right after rst");

endmodule

bind MilSpiBridge MilSpiBridgeSva sva (
  .clk(clk), .rst(rst), .milTx(milTx), .resetRequest(resetRequest),
  .hdrStrobe(hdrStrobe), .rxStrobe(rxStrobe), .txPop(txPop), .frameEnd(frameEnd)
);

// File: sim/MilSpiBridgeTb.sv
module MilSpiBridgeTb import MilSpiPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_SCLK       = 4;  // clk cycles per sclk phase
  localparam int SPI_WORD_CYCLES = 2 * HALF_SCLK * WORD_W;  // far above the pacing gap
  localparam int TIMEOUT_CYCLES  = 20000;

  logic clk;
  logic rst;
  logic sclk;
  logic csN;
  logic mosi;
  logic miso;
  logic resetRequest;
  TMilWord milRx;
  TMilWord milTx;
  int cycle;
  int errors;
  int checks;
  int seed;
  logic [WORD_W-1:0] spiOut[$];  // data words for the next frame
  logic [WORD_W-1:0] spiIn[$];   // miso words of the last frame
  logic [WORD_W-1:0] stored[$];  // words sent on milRx, in order
  logic [WORD_W-1:0] txSeen[$];
  int txCycle[$];

  MilSpiBridge DUT (
    .clk(clk), .rst(rst), .sclk(sclk), .csN(csN), .mosi(mosi), .miso(miso),
    .milRx(milRx), .milTx(milTx), .resetRequest(resetRequest)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a test did not finish", cycle);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // milTx monitor
  always @(posedge clk) begin
    if (milTx.strobe) begin
      txSeen.push_back(milTx.data);
      txCycle.push_back(cycle);
    end
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // mosi moves with the falling edge and miso is read while sclk is high
  task automatic spiFrame(input logic [WORD_W-1:0] header, input int nWords);
    logic [WORD_W-1:0] word;
    logic [WORD_W-1:0] got;
    spiIn.delete();
    csN <= 1'b0;
    waitCycles(HALF_SCLK);
    for (int w = 0; w <= nWords; w++) begin
      if (w == 0) word = header;
      else word = (w - 1 < spiOut.size()) ? spiOut[w - 1] : '0;
      for (int b = WORD_W - 1; b >= 0; b--) begin
        mosi <= word[b];
        waitCycles(HALF_SCLK);
        sclk <= 1'b1;
        waitCycles(HALF_SCLK);
        got[b] = miso;
        sclk <= 1'b0;
      end
      if (w > 0) spiIn.push_back(got);
    end
    waitCycles(HALF_SCLK);
    csN <= 1'b1;
    waitCycles(2 * HALF_SCLK);  // frameEnd settles before the next frame
  endtask

  task automatic milSend(input int n);
    logic [WORD_W-1:0] word;
    repeat (n) begin
      word = WORD_W'($random(seed));
      stored.push_back(word);
      milRx.strobe <= 1'b1;
      milRx.data   <= word;
      @(posedge clk);
      milRx.strobe <= 1'b0;
      @(posedge clk);
    end
  endtask

  task automatic testSendData();
    spiOut.delete();
    txSeen.delete();
    txCycle.delete();
    repeat (5) spiOut.push_back(WORD_W'($random(seed)));
    spiFrame({BLOCK_ADDR, CMD_SEND_DATA}, 5);
    while (txSeen.size() < 5) @(posedge clk);
    waitCycles(4 * MIL_WORD_GAP);
    checkValue("testSendData count", 5, txSeen.size());
    for (int i = 0; i < 5; i++) begin
      checkValue("testSendData word", spiOut[i], txSeen[i]);
      if (i > 0) checkValue("testSendData gap", SPI_WORD_CYCLES, txCycle[i] - txCycle[i - 1]);
    end
  endtask

  task automatic testStatus();
    stored.delete();
    milSend(4);
    spiOut.delete();
    spiFrame({BLOCK_ADDR, CMD_RECEIVE_STS}, 3);
    checkValue("testStatus fromMil used", 4, spiIn[0]);
    checkValue("testStatus toMil used", 0, spiIn[1]);
    checkValue("testStatus spare word", 0, spiIn[2]);
  endtask

  task automatic testReceiveData();
    spiFrame({BLOCK_ADDR, CMD_RECEIVE_DATA}, 5);
    for (int i = 0; i < 4; i++) checkValue("testReceiveData word", stored[i], spiIn[i]);
    checkValue("testReceiveData drained", 0, spiIn[4]);
    spiFrame({BLOCK_ADDR, CMD_RECEIVE_STS}, 2);
    checkValue("testReceiveData fromMil used", 0, spiIn[0]);
    checkValue("testReceiveData toMil used", 0, spiIn[1]);
  endtask

  task automatic testWrongAddr();
    int seenBefore;
    seenBefore = txSeen.size();
    repeat (2) spiOut.push_back(WORD_W'($random(seed)));
    spiFrame({8'h12, CMD_SEND_DATA}, 2);
    waitCycles(200);
    checkValue("testWrongAddr milTx strobes", seenBefore, txSeen.size());
    stored.delete();
    milSend(2);  // a matching status read would now be nonzero
    spiOut.delete();
    spiFrame({8'h12, CMD_RECEIVE_STS}, 2);
    checkValue("testWrongAddr status 0", 0, spiIn[0]);
    checkValue("testWrongAddr status 1", 0, spiIn[1]);
  endtask

  task automatic testOverflow();
    milSend(20);
    spiFrame({BLOCK_ADDR, CMD_RECEIVE_STS}, 1);
    checkValue("testOverflow fromMil used", FIFO_DEPTH, spiIn[0]);
    spiFrame({BLOCK_ADDR, CMD_RECEIVE_DATA}, FIFO_DEPTH);
    for (int i = 0; i < FIFO_DEPTH; i++) checkValue("testOverflow word", stored[i], spiIn[i]);
  endtask

  task automatic testResetCmd();
    checkValue("testResetCmd request idle", 0, resetRequest);
    spiFrame({BLOCK_ADDR, CMD_RESET}, 0);
    checkValue("testResetCmd request set", 1, resetRequest);
    waitCycles(50);
    checkValue("testResetCmd request held", 1, resetRequest);
    rst <= 1'b1;
    waitCycles(1);
    rst <= 1'b0;
    waitCycles(1);
    checkValue("testResetCmd request cleared", 0, resetRequest);
  endtask

  initial begin
    seed   = 32'h4564_4110;
    cycle  = 0;
    errors = 0;
    checks = 0;
    rst    = 1'b1;
    sclk   = 1'b0;
    csN    = 1'b1;
    mosi   = 1'b0;
    milRx  = '0;
    waitCycles(3);
    rst <= 1'b0;
    waitCycles(1);
    testSendData();
    testStatus();
    testReceiveData();
    testWrongAddr();
    testOverflow();
    testResetCmd();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: MilSpiBridge.f
rtl/MilSpiPkg.sv
rtl/SpiLink.sv
rtl/WordFifo.sv
rtl/MilSpiBlock.sv
rtl/MilTxPacer.sv
rtl/MilSpiBridge.sv
sim/MilSpiBridge_sva.sv
sim/MilSpiBridgeTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f MilSpiBridge.f \
  --top-module MilSpiBridgeTb -o simv > build.log 2>&1 \
  || { echo "build failed"; cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
